// ==== spc_pkg.sv ====
// shared types for the spc700-style cpu subset
// data bytes are 8 bits and addresses 16 bits, no other widths are supported
// register indices double as register file addresses, reg_null reads zero
// the debug snapshot carries sp as well, so it is 56 bits wide
`default_nettype none

package spc_pkg;

	localparam int data_width = 8;
	localparam int addr_width = 16;

	typedef logic [data_width-1:0] byte_t;
	typedef logic [addr_width-1:0] addr_t;

	// one instruction at a time walks through these
	typedef enum logic [2:0] {
		stage_fetch,
		stage_decode,
		stage_param,   // second byte of a two-byte instruction
		stage_compute,
		stage_write,
		stage_delay    // keeps the original hardware pace
	} stage_e;

	typedef enum logic [2:0] {
		alu_or,
		alu_and,
		alu_xor,
		alu_andnot,
		alu_add,
		alu_sub,
		alu_pass_a,
		alu_pass_b
	} alu_op_e;

	typedef enum logic [2:0] {
		reg_a,
		reg_x,
		reg_y,
		reg_sp,
		reg_psw,
		reg_d1,    // virtual, for immediates
		reg_d2,    // virtual, for immediates
		reg_null   // always reads zero
	} reg_idx_e;

	// psw bit positions
	localparam int psw_n = 0;
	localparam int psw_v = 1;
	localparam int psw_p = 2; // direct page
	localparam int psw_b = 3;
	localparam int psw_h = 4;
	localparam int psw_i = 5;
	localparam int psw_z = 6;
	localparam int psw_c = 7;

	typedef struct packed {
		alu_op_e  alu_op;
		reg_idx_e src_a_idx;
		reg_idx_e src_b_idx;
		logic     src_b_is_imm; // imm replaces register b
		byte_t    imm;
		logic     fetch_b;      // operand b from the next byte
		logic     fetch_a;      // operand a from the next byte
		logic     use_carry;    // carry-in from psw c
		reg_idx_e dest_idx;
		logic     two_byte;
	} micro_op_t;

	typedef struct packed {
		byte_t a;
		byte_t x;
		byte_t y;
		byte_t sp;
		byte_t psw;
		addr_t pc;
	} dbg_regs_t;

endpackage

`default_nettype wire

// ==== spc_decoder.sv ====
// combinational opcode decoder, two opcode columns only
// status column xxx_000_00 and immediate column xxx_010_00
// any other opcode raises invalid, uop is then a harmless nop
`timescale 1ns/1ps
`default_nettype none

module spc_decoder import spc_pkg::*; (
	input  byte_t     opcode,
	output micro_op_t uop,
	output logic      invalid
);

	logic [2:0]  sel;      // xxx field, picks the row in a column
	int unsigned flag_bit; // psw bit touched by a status instruction
	logic        flag_set;

	assign sel = opcode[7:5];

	// status row to flag bit and polarity
	always_comb begin
		flag_bit = psw_p;
		flag_set = 1'b0;
		case (sel)
			3'd1: flag_bit = psw_p;  // clp
			3'd2: begin              // sep
				flag_bit = psw_p;
				flag_set = 1'b1;
			end
			3'd3: flag_bit = psw_c;  // clc
			3'd4: begin              // sec
				flag_bit = psw_c;
				flag_set = 1'b1;
			end
			3'd5: flag_bit = psw_i;  // cli
			3'd6: begin              // sei
				flag_bit = psw_i;
				flag_set = 1'b1;
			end
			3'd7: flag_bit = psw_v;  // clv
			default: flag_bit = psw_p; // nop row, unused
		endcase
	end

	always_comb begin
		uop = '0;
		uop.alu_op = alu_pass_a;
		uop.src_a_idx = reg_a;
		uop.src_b_idx = reg_null;
		uop.dest_idx = reg_null; // default writes nowhere
		invalid = 1'b0;

		case (opcode[4:0])
			5'b000_00: begin
				if (sel != 3'd0) begin
					// psw | mask or psw & ~mask
					uop.alu_op = flag_set ? alu_or : alu_andnot;
					uop.src_a_idx = reg_psw;
					uop.src_b_is_imm = 1'b1;
					uop.imm = byte_t'(1) << flag_bit;
					uop.dest_idx = reg_psw;
				end
			end

			5'b010_00: begin
				uop.fetch_b = 1'b1;
				uop.two_byte = 1'b1;
				uop.dest_idx = reg_a;
				case (sel)
					3'd0: uop.alu_op = alu_or;
					3'd1: uop.alu_op = alu_and;
					3'd2: uop.alu_op = alu_xor;
					3'd3: begin // cmp, result dropped
						uop.alu_op = alu_sub;
						uop.dest_idx = reg_null;
					end
					3'd4: begin // adc
						uop.alu_op = alu_add;
						uop.use_carry = 1'b1;
					end
					3'd5: begin // sbc
						uop.alu_op = alu_sub;
						uop.use_carry = 1'b1;
					end
					3'd6: begin // cpx
						uop.alu_op = alu_sub;
						uop.src_a_idx = reg_x;
						uop.dest_idx = reg_null;
					end
					default: begin // lda, byte lands in a and passes through
						uop.fetch_a = 1'b1;
						uop.fetch_b = 1'b0;
					end
				endcase
			end

			default: invalid = 1'b1;
		endcase
	end

	// a halting opcode must not ask for a parameter fetch
	always_comb begin
		assert (!(invalid && uop.two_byte));
	end

endmodule

`default_nettype wire

// ==== spc_regfile.sv ====
// eight byte registers, two async read ports and one write port
// reg_null reads zero and ignores writes, all registers clear on reset
// pc is owned by the sequencer and only joins the debug snapshot here
`timescale 1ns/1ps
`default_nettype none

module spc_regfile import spc_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  reg_idx_e  rd_a_idx,
	input  reg_idx_e  rd_b_idx,
	output byte_t     rd_a_data,
	output byte_t     rd_b_data,
	input  logic      wr_en,
	input  reg_idx_e  wr_idx,
	input  byte_t     wr_data,
	input  addr_t     pc,
	output dbg_regs_t dbg
);

	byte_t regs [8];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != reg_null) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign rd_a_data = (rd_a_idx == reg_null) ? '0 : regs[rd_a_idx];
	assign rd_b_data = (rd_b_idx == reg_null) ? '0 : regs[rd_b_idx];

	// snapshot follows the registers with no extra delay
	assign dbg.a   = regs[reg_a];
	assign dbg.x   = regs[reg_x];
	assign dbg.y   = regs[reg_y];
	assign dbg.sp  = regs[reg_sp];
	assign dbg.psw = regs[reg_psw];
	assign dbg.pc  = pc;

	// the sequencer must keep its write strobe quiet while reset is held
	assert property (@(posedge clock) reset |-> !wr_en);

endmodule

`default_nettype wire

// ==== spc_alu.sv ====
// eight-operation byte alu, purely combinational
// no flags are produced, psw only changes through status instructions
// carry_in is chosen by the sequencer: 1 means no borrow for sub
`timescale 1ns/1ps
`default_nettype none

module spc_alu import spc_pkg::*; (
	input  alu_op_e op,
	input  byte_t   a,
	input  byte_t   b,
	input  logic    carry_in,
	output byte_t   result
);

	always_comb begin
		case (op)
			alu_or:     result = a | b;
			alu_and:    result = a & b;
			alu_xor:    result = a ^ b;
			alu_andnot: result = a & ~b;                   // flag clears
			alu_add:    result = a + b + byte_t'(carry_in);
			alu_sub:    result = a - b - byte_t'(!carry_in); // borrow is inverted carry
			alu_pass_a: result = a;
			alu_pass_b: result = b;
			default:    result = a;
		endcase
	end

endmodule

`default_nettype wire

// ==== spc_sequencer.sv ====
// stage machine for one instruction in flight, no pipelining
// ram is synchronous with a one-cycle read, address is registered here
// one-byte instructions take 5 cycles, two-byte ones 6
// an invalid opcode freezes the machine in decode until reset
`timescale 1ns/1ps
`default_nettype none

module spc_sequencer import spc_pkg::*; #(
	parameter addr_t reset_pc = '0
) (
	input  logic      clock,
	input  logic      reset,
	input  byte_t     ram_read_data,
	output addr_t     ram_address,
	input  micro_op_t uop,
	input  logic      invalid,
	input  byte_t     rd_a_data,
	input  byte_t     rd_b_data,
	input  logic      psw_carry,
	output alu_op_e   alu_op,
	output byte_t     op_a,
	output byte_t     op_b,
	output logic      carry_in,
	input  byte_t     alu_result,
	output logic      wr_en,
	output reg_idx_e  wr_idx,
	output byte_t     wr_data,
	output addr_t     pc,
	output logic      halted
);

	stage_e    stage;
	micro_op_t cur_uop; // micro-op of the instruction in flight
	byte_t     result;

	// control state
	always_ff @(posedge clock) begin
		if (reset) begin
			stage <= stage_fetch;
			pc <= reset_pc;
			ram_address <= reset_pc; // first fetch address
			halted <= 1'b0;
			wr_en <= 1'b0;
		end else if (!halted) begin
			wr_en <= 1'b0;
			case (stage)
				stage_fetch: begin
					ram_address <= pc + addr_t'(1); // operand byte, read even if unused
					stage <= stage_decode;
				end
				stage_decode: begin
					if (invalid)
						halted <= 1'b1; // stage stays frozen here
					else
						stage <= uop.two_byte ? stage_param : stage_compute;
				end
				stage_param: stage <= stage_compute;
				stage_compute: begin
					pc <= pc + (cur_uop.two_byte ? addr_t'(2) : addr_t'(1));
					wr_en <= 1'b1; // high for the whole write stage
					stage <= stage_write;
				end
				stage_write: stage <= stage_delay;
				stage_delay: begin
					ram_address <= pc; // next opcode
					stage <= stage_fetch;
				end
				default: stage <= stage_fetch;
			endcase
		end
	end

	// operand and result latches
	always_ff @(posedge clock) begin
		if (!halted) begin
			case (stage)
				stage_decode: begin
					cur_uop <= uop;
					op_a <= rd_a_data;
					op_b <= uop.src_b_is_imm ? uop.imm : rd_b_data;
				end
				stage_param: begin
					// ram now holds the byte at pc+1
					if (cur_uop.fetch_a)
						op_a <= ram_read_data;
					if (cur_uop.fetch_b)
						op_b <= ram_read_data;
				end
				stage_compute: result <= alu_result;
				default: ;
			endcase
		end
	end

	assign alu_op = cur_uop.alu_op;
	// plain add and sub when the carry flag is not wanted
	assign carry_in = cur_uop.use_carry ? psw_carry : (cur_uop.alu_op == alu_sub);
	assign wr_idx = cur_uop.dest_idx;
	assign wr_data = result;

	assert property (@(posedge clock) disable iff (reset)
		stage == stage_param |-> cur_uop.two_byte);

	// only reset leaves the halted state
	assert property (@(posedge clock) $fell(halted) |-> $past(reset));

endmodule

`default_nettype wire

// ==== spc_cpu.sv ====
// top level of the cpu subset, wiring only
// external ram is synchronous, data for ram_address arrives one cycle later
// there are no memory writes, dbg shows the architectural registers and pc
`timescale 1ns/1ps
`default_nettype none

module spc_cpu import spc_pkg::*; #(
	parameter addr_t reset_pc = '0
) (
	input  logic      clock,
	input  logic      reset,
	input  byte_t     ram_read_data,
	output addr_t     ram_address,
	output logic      halted,
	output dbg_regs_t dbg
);

	micro_op_t uop;
	logic      invalid;
	byte_t     rd_a_data;
	byte_t     rd_b_data;
	alu_op_e   alu_op;
	byte_t     op_a;
	byte_t     op_b;
	logic      carry_in;
	byte_t     alu_result;
	logic      wr_en;
	reg_idx_e  wr_idx;
	byte_t     wr_data;
	addr_t     pc;
	logic      psw_carry;

	assign psw_carry = dbg.psw[psw_c];

	// opcode goes straight from ram, sampled by the sequencer in decode
	spc_decoder u_decoder (
		.opcode  (ram_read_data),
		.uop     (uop),
		.invalid (invalid)
	);

	spc_regfile u_regfile (
		.clock     (clock),
		.reset     (reset),
		.rd_a_idx  (uop.src_a_idx),
		.rd_b_idx  (uop.src_b_idx),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_data   (wr_data),
		.pc        (pc),
		.dbg       (dbg)
	);

	spc_alu u_alu (
		.op       (alu_op),
		.a        (op_a),
		.b        (op_b),
		.carry_in (carry_in),
		.result   (alu_result)
	);

	spc_sequencer #(
		.reset_pc (reset_pc)
	) u_sequencer (
		.clock         (clock),
		.reset         (reset),
		.ram_read_data (ram_read_data),
		.ram_address   (ram_address),
		.uop           (uop),
		.invalid       (invalid),
		.rd_a_data     (rd_a_data),
		.rd_b_data     (rd_b_data),
		.psw_carry     (psw_carry),
		.alu_op        (alu_op),
		.op_a          (op_a),
		.op_b          (op_b),
		.carry_in      (carry_in),
		.alu_result    (alu_result),
		.wr_en         (wr_en),
		.wr_idx        (wr_idx),
		.wr_data       (wr_data),
		.pc            (pc),
		.halted        (halted)
	);

endmodule

`default_nettype wire

// ==== tb_spc_cpu.sv ====
// testbench for the spc700-style cpu subset
// ram is a 64 KB array that answers one cycle after the registered address
// program runs the status instructions then random immediate ops and ends on an invalid opcode
// a model of a x and psw is compared with dbg at every opcode decode
// x is never loaded so cpx always compares against zero
`timescale 1ns/1ps
`default_nettype none

module tb_spc_cpu import spc_pkg::*; ();

	// nop sep sec sei clv clp cli clc sec
	localparam byte_t status_ops [9] = '{8'h00, 8'h40, 8'h80, 8'hc0, 8'he0,
		8'h20, 8'ha0, 8'h60, 8'h80};

	logic      clock;
	logic      reset;
	byte_t     ram_read_data;
	addr_t     ram_address;
	logic      halted;
	dbg_regs_t dbg;

	byte_t  mem [65536];
	byte_t  m_a;            // model registers
	byte_t  m_x;
	byte_t  m_psw;
	addr_t  m_pc;
	logic   prev_eq;        // ram_address matched dbg.pc in the last cycle
	integer seed;
	int     errors = 0;
	int     halt_errors = 0;
	int     pc_errors = 0;

	spc_cpu #(
		.reset_pc (16'h0200)
	) u_dut (
		.clock         (clock),
		.reset         (reset),
		.ram_read_data (ram_read_data),
		.ram_address   (ram_address),
		.halted        (halted),
		.dbg           (dbg)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// address held before an edge returns its data 1 ns after that edge
	initial begin : ram_model
		addr_t addr_l;
		ram_read_data = '0;
		forever begin
			@(negedge clock);
			addr_l = ram_address;
			@(posedge clock);
			#1 ram_read_data = mem[addr_l];
		end
	end

	// a halted cpu stays halted and frozen
	assert property (@(posedge clock) disable iff (reset)
		halted |=> halted && $stable(ram_address) && $stable(dbg))
		else begin
			halt_errors++;
			$display("halted cpu changed its address, registers or halt state");
		end

	assert property (@(posedge clock) disable iff (reset)
		!$stable(dbg.pc) |->
			dbg.pc == $past(dbg.pc) + 16'd1 || dbg.pc == $past(dbg.pc) + 16'd2)
		else begin
			pc_errors++;
			$display("ERR dbg.pc: stepped to %h by neither 1 nor 2", dbg.pc);
		end

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got == exp) else begin
			errors++;
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_state();
		check("dbg.a", 16'(dbg.a), 16'(m_a));
		check("dbg.x", 16'(dbg.x), 16'(m_x));
		check("dbg.y", 16'(dbg.y), 16'h0000);
		check("dbg.sp", 16'(dbg.sp), 16'h0000);
		check("dbg.psw", 16'(dbg.psw), 16'(m_psw));
		check("dbg.pc", dbg.pc, m_pc);
		check("halted", 16'(halted), 16'h0000);
	endtask

	// psw bits used here are c 7, i 5, p 2 and v 1
	task automatic model_step(input byte_t opc, input byte_t arg,
		output logic ok, output int len);
		ok = 1'b1;
		len = (opc[4:0] == 5'b01000) ? 2 : 1; // immediate column carries a byte
		case (opc)
			8'h00: ;                                    // nop
			8'h20: m_psw[2] = 1'b0;                     // clp
			8'h40: m_psw[2] = 1'b1;                     // sep
			8'h60: m_psw[7] = 1'b0;                     // clc
			8'h80: m_psw[7] = 1'b1;                     // sec
			8'ha0: m_psw[5] = 1'b0;                     // cli
			8'hc0: m_psw[5] = 1'b1;                     // sei
			8'he0: m_psw[1] = 1'b0;                     // clv
			8'h08: m_a = m_a | arg;                     // ora
			8'h28: m_a = m_a & arg;
			8'h48: m_a = m_a ^ arg;
			8'h68: ;                                    // cmp drops its result
			8'h88: m_a = m_a + arg + {7'd0, m_psw[7]};  // adc
			8'ha8: m_a = m_a + ~arg + {7'd0, m_psw[7]}; // sbc as a + ~b + c
			8'hc8: ;                                    // cpx
			8'he8: m_a = arg;                           // lda
			default: ok = 1'b0;
		endcase
	endtask

	task automatic build_program();
		addr_t p;
		int    r;
		for (int i = 0; i < 65536; i++) begin
			mem[addr_t'(i)] = i[15:8] ^ i[7:0];
		end
		p = 16'h0200;
		for (int k = 0; k < 9; k++) begin
			mem[p] = status_ops[4'(k)];
			p = p + 16'd1;
		end
		for (int n = 0; n < 48; n++) begin
			r = $random(seed) & 255;
			if (r % 10 < 8) begin
				mem[p] = {3'(r % 10), 5'b01000}; // row picks the operation
				mem[p + 16'd1] = byte_t'($random(seed));
				p = p + 16'd2;
			end else begin
				// sec or clc so adc and sbc see both carries
				mem[p] = (r % 10 == 8) ? 8'h80 : 8'h60;
				p = p + 16'd1;
			end
		end
		mem[p] = 8'hff;
	endtask

	// a decode cycle follows a fetch where ram_address equalled dbg.pc
	task automatic wait_decode(output int n);
		logic found;
		n = 0;
		found = 1'b0;
		while (!found && n < 200) begin
			@(negedge clock);
			n++;
			found = (ram_address == dbg.pc + 16'd1) && prev_eq;
			prev_eq = (ram_address == dbg.pc);
		end
		if (!found) begin
			errors++;
			$display("timeout: no instruction fetch within 200 cycles");
			n = -1;
		end
	endtask

	task automatic check_halt();
		int        n;
		dbg_regs_t snap;
		addr_t     addr_snap;
		n = 0;
		while (!halted && n < 200) begin
			@(negedge clock);
			n++;
		end
		if (!halted) begin
			errors++;
			$display("timeout: halted did not rise after the invalid opcode");
		end else begin
			check("halt latency", 16'(n), 16'd1); // end of the decode stage
			snap = dbg;
			addr_snap = ram_address;
			repeat (20) begin
				@(negedge clock);
				check("halted", 16'(halted), 16'd1);
				check("ram_address", ram_address, addr_snap);
				assert (dbg == snap) else begin
					errors++;
					$display("ERR dbg: got %h, expected %h", dbg, snap);
				end
			end
		end
	endtask

	initial begin : main
		int   n;
		int   len;
		int   prev_len;
		logic ok;
		logic done;
		reset = 1'b1;
		seed = 32'hf81ca237;
		m_a = '0;
		m_x = '0;
		m_psw = '0;
		m_pc = 16'h0200;
		build_program();
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;
		@(negedge clock);
		check_state();
		check("ram_address", ram_address, 16'h0200); // first fetch
		prev_eq = (ram_address == dbg.pc);
		prev_len = 0;
		done = 1'b0;
		while (!done) begin
			wait_decode(n);
			if (n < 0) begin
				done = 1'b1;
			end else begin
				if (prev_len != 0)
					check("fetch spacing", 16'(n), 16'(prev_len + 4));
				check_state(); // shows the previous instruction's result
				model_step(mem[m_pc], mem[m_pc + 16'd1], ok, len);
				if (ok) begin
					m_pc = m_pc + 16'(len);
					prev_len = len;
				end else begin
					done = 1'b1;
				end
			end
		end
		if (n >= 0)
			check_halt();
		$display("errors: %0d in checks, %0d in halt property, %0d in pc property",
			errors, halt_errors, pc_errors);
		if (errors + halt_errors + pc_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
spc_pkg.sv
spc_decoder.sv
spc_regfile.sv
spc_alu.sv
spc_sequencer.sv
spc_cpu.sv
tb_spc_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compiles and runs the cpu testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_spc_cpu \
	-f build.f -o tb_spc_cpu_sim
./obj_dir/tb_spc_cpu_sim | tee sim.log
if grep -q "Test completed successfully" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
